// ==== i2s_audio_pkg.sv ====
// audio side types for the i2s receiver
// samples, stereo words, fifo counters and the dma state machine
`include "i2s_rx_config.svh"

package i2s_audio_pkg;

    // ----------------------------------------------------------------------
    // sample data
    // ----------------------------------------------------------------------
    typedef logic [`I2S_SLOT_BITS-1:0]   sample_t;      // one channel
    typedef logic [2*`I2S_SLOT_BITS-1:0] stereo_word_t; // left high, right low

    // bit position within a slot, 0 to slot width
    typedef logic [$clog2(`I2S_SLOT_BITS+1)-1:0] bitcnt_t;

    // ----------------------------------------------------------------------
    // fifo bookkeeping
    // ----------------------------------------------------------------------
    typedef logic [$clog2(`I2S_FIFO_DEPTH+1)-1:0] fifo_level_t; // 0 .. depth
    typedef logic [$clog2(`I2S_FIFO_DEPTH)-1:0]   fifo_ptr_t;   // wraps at depth

    // dma handshake states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,  // waiting for level
        REQ    = 2'd1,  // request raised
        ACTIVE = 2'd2   // burst under way
    } dma_state_e;

endpackage

// ==== i2s_dma_request.sv ====
`timescale 1ns/100ps
// single channel dma request handshake, req then active then done
module i2s_dma_request (
    input  logic           wb_clk_i,
    input  logic           reset_i,
    i2s_rx_cfg_if.datapath cfg,
    output logic           sdma_req_o,
    input  logic           sdma_active_i,  // controller servicing the request
    input  logic           sdma_done_i,    // one-cycle end of burst
    output logic           dma_done_o
);
    import i2s_audio_pkg::*;

    dma_state_e state_q;
    dma_state_e state_d;
    logic       level_hit;

    // zero threshold never requests
    assign level_hit = cfg.dma_enable &
                       (cfg.threshold != '0) &
                       (cfg.fifo_level >= cfg.threshold);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (level_hit) state_d = REQ;
            REQ: begin
                if (!cfg.dma_enable) begin
                    state_d = IDLE;         // withdrawn before service
                end else if (sdma_active_i) begin
                    state_d = ACTIVE;
                end
            end
            ACTIVE:  if (sdma_done_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign sdma_req_o = (state_q == REQ);
    assign dma_done_o = (state_q == ACTIVE) & sdma_done_i;  // burst finished

endmodule

// ==== i2s_rx_cfg_if.sv ====
`timescale 1ns/100ps
// control and status between the register block and the receive datapath
interface i2s_rx_cfg_if;
    import i2s_audio_pkg::*;

    logic         rx_enable;     // receive on, low flushes the fifo
    logic         dma_enable;    // allow dma requests
    fifo_level_t  threshold;     // level for irq and dma
    logic         pop;           // one-cycle pop of the head word
    logic         ovf_clr;       // clears sticky overflow
    fifo_level_t  fifo_level;    // current occupancy
    logic         fifo_overflow; // sticky, word was dropped
    stereo_word_t pop_data;      // head word, zero when empty

    // register side drives control
    modport regs (
        output rx_enable, dma_enable, threshold, pop, ovf_clr,
        input  fifo_level, fifo_overflow, pop_data
    );

    // datapath blocks drive status, each uses its own subset
    modport datapath (
        input  rx_enable, dma_enable, threshold, pop, ovf_clr,
        output fifo_level, fifo_overflow, pop_data
    );

endinterface

// ==== i2s_rx_config.svh ====
// i2s receive subsystem configuration
// fifo sizing, slot width, register map and device id
`ifndef I2S_RX_CONFIG_SVH
`define I2S_RX_CONFIG_SVH

// ----------------------------------------------------------------------
// datapath sizing
// ----------------------------------------------------------------------
`define I2S_FIFO_DEPTH 16   // stereo words, keep a power of two
`define I2S_SLOT_BITS  16   // bits per left or right slot

// ----------------------------------------------------------------------
// register map, byte offsets on the wishbone address
// ----------------------------------------------------------------------
`define I2S_REG_CTRL   17'h00000
`define I2S_REG_STATUS 17'h00004
`define I2S_REG_DATA   17'h00008
`define I2S_REG_ID     17'h0000C

// read-only id word, lower 20 bits of the ID register
`define I2S_DEVICE_ID  20'h1252B

`endif

// ==== i2s_rx_deserializer.sv ====
`timescale 1ns/100ps
// i2s slave deserializer, pins oversampled on the wishbone clock
// assembles left/right slots into stereo words for the fifo
`include "i2s_rx_config.svh"

module i2s_rx_deserializer (
    input  logic                        wb_clk_i,
    input  logic                        reset_i,
    input  logic                        i2s_clk_i,   // bit clock
    input  logic                        i2s_ws_i,    // low left, high right
    input  logic                        i2s_din_i,
    i2s_rx_cfg_if.datapath              cfg,
    output logic                        push_o,      // one cycle per stereo word
    output i2s_audio_pkg::stereo_word_t push_data_o
);
    import i2s_audio_pkg::*;

    localparam bitcnt_t SLOT_LAST = bitcnt_t'(`I2S_SLOT_BITS);

    logic [1:0] clk_sync;
    logic [1:0] ws_sync;
    logic [1:0] din_sync;
    logic       clk_d;        // previous synced bit clock
    logic       bclk_rise;
    logic       ws_last;      // ws seen at the previous bit clock edge
    logic       ws_change;
    logic       armed;        // frame began with receive enabled
    logic       slot_done;
    bitcnt_t    bit_cnt;
    bitcnt_t    bit_cnt_nxt;
    sample_t    left_sr;
    sample_t    right_sr;

    // ----------------------------------------------------------------------
    // pin synchronizers and bit clock edge detect
    // ----------------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            clk_sync <= '0;
            ws_sync  <= '0;
            din_sync <= '0;
            clk_d    <= 1'b0;
        end else begin
            clk_sync <= {clk_sync[0], i2s_clk_i};
            ws_sync  <= {ws_sync[0], i2s_ws_i};
            din_sync <= {din_sync[0], i2s_din_i};
            clk_d    <= clk_sync[1];
        end
    end

    assign bclk_rise = clk_sync[1] & ~clk_d;
    assign ws_change = ws_sync[1] ^ ws_last;

    // msb is on the first edge after ws moves, count saturates at the slot end
    assign bit_cnt_nxt = ws_change              ? bitcnt_t'(1) :
                         (bit_cnt == SLOT_LAST) ? bit_cnt :
                                                  bit_cnt + bitcnt_t'(1);

    // edge carrying the last right-slot bit
    assign slot_done = bclk_rise & ws_sync[1] & (bit_cnt_nxt == SLOT_LAST);

    // ----------------------------------------------------------------------
    // frame tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ws_last <= 1'b1;   // so a left slot right after reset counts as a start
            bit_cnt <= '0;
            armed   <= 1'b0;
            push_o  <= 1'b0;
        end else begin
            push_o <= slot_done & armed & cfg.rx_enable;
            if (bclk_rise && ws_change && !ws_sync[1]) begin
                armed <= cfg.rx_enable;   // left slot start
            end else if (!cfg.rx_enable) begin
                armed <= 1'b0;            // partial frame is thrown away
            end
            if (bclk_rise) begin
                ws_last <= ws_sync[1];
                bit_cnt <= bit_cnt_nxt;
            end
        end
    end

    // shift registers, msb first
    always_ff @(posedge wb_clk_i) begin
        if (bclk_rise) begin
            if (ws_sync[1]) begin
                right_sr <= {right_sr[`I2S_SLOT_BITS-2:0], din_sync[1]};
            end else begin
                left_sr  <= {left_sr[`I2S_SLOT_BITS-2:0], din_sync[1]};
            end
        end
    end

    assign push_data_o = {left_sr, right_sr}; // stable until the next bit edge

endmodule

// ==== i2s_rx_regs.sv ====
`timescale 1ns/100ps
// wishbone slave registers for the i2s receiver
// ctrl, status, fifo data pop, device id and the three interrupts
`include "i2s_rx_config.svh"

module i2s_rx_regs (
    input  logic                  wb_clk_i,
    input  logic                  reset_i,
    input  wb_bus_pkg::wb_addr_t  wb_adr_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  wb_bus_pkg::wb_sel_t   wb_sel_i,
    input  wb_bus_pkg::wb_data_t  wb_dat_i,
    output wb_bus_pkg::wb_data_t  wb_dat_o,
    output logic                  wb_ack_o,
    i2s_rx_cfg_if.regs            cfg,
    input  logic                  dma_done_i,
    output logic                  rx_intr_o,
    output logic                  dma_intr_o,
    output logic                  ovf_intr_o
);
    import wb_bus_pkg::*;
    import i2s_audio_pkg::*;

    logic        wb_req;
    logic        wr_cyc;
    logic        rd_cyc;
    logic        ctrl_hit;
    logic        status_hit;
    logic        data_hit;
    logic        id_hit;
    logic        rx_en_q;
    logic        dma_en_q;
    logic [2:0]  irq_en_q;     // {ovf, dma, rx}
    fifo_level_t thresh_q;
    logic        dma_done_q;   // sticky
    wb_data_t    ctrl_rd;
    wb_data_t    status_rd;

    // ----------------------------------------------------------------------
    // bus handshake
    // ----------------------------------------------------------------------
    assign wb_req = wb_cyc_i & wb_stb_i;

    // single-cycle ack, the master drops stb after it
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req & ~wb_ack_o;
        end
    end

    // address is still held in the ack cycle, so the access completes there
    assign wr_cyc     = wb_ack_o & wb_we_i;
    assign rd_cyc     = wb_ack_o & ~wb_we_i;
    assign ctrl_hit   = (wb_adr_i == `I2S_REG_CTRL);
    assign status_hit = (wb_adr_i == `I2S_REG_STATUS);
    assign data_hit   = (wb_adr_i == `I2S_REG_DATA);
    assign id_hit     = (wb_adr_i == `I2S_REG_ID);

    // ----------------------------------------------------------------------
    // control register
    // ----------------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            rx_en_q  <= 1'b0;
            dma_en_q <= 1'b0;
            irq_en_q <= '0;
            thresh_q <= '0;
        end else if (wr_cyc && ctrl_hit) begin
            if (wb_sel_i[0]) begin
                rx_en_q  <= wb_dat_i[0];
                dma_en_q <= wb_dat_i[1];
                irq_en_q <= wb_dat_i[4:2];
            end
            if (wb_sel_i[1]) thresh_q <= wb_dat_i[12:8];
        end
    end

    // dma done sticky, a new pulse beats a write-1 clear
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            dma_done_q <= 1'b0;
        end else if (dma_done_i) begin
            dma_done_q <= 1'b1;
        end else if (wr_cyc && status_hit && wb_dat_i[9]) begin
            dma_done_q <= 1'b0;
        end
    end

    assign cfg.rx_enable  = rx_en_q;
    assign cfg.dma_enable = dma_en_q;
    assign cfg.threshold  = thresh_q;
    assign cfg.ovf_clr    = wr_cyc & status_hit & wb_dat_i[8];  // w1c
    assign cfg.pop        = rd_cyc & data_hit;  // head word leaves after this read

    // ----------------------------------------------------------------------
    // read mux
    // ----------------------------------------------------------------------
    assign ctrl_rd   = {19'b0, thresh_q, 3'b0, irq_en_q, dma_en_q, rx_en_q};
    assign status_rd = {22'b0, dma_done_q, cfg.fifo_overflow, 3'b0, cfg.fifo_level};

    always_comb begin
        wb_dat_o = '0;
        if (ctrl_hit)   wb_dat_o = ctrl_rd;
        if (status_hit) wb_dat_o = status_rd;
        if (data_hit)   wb_dat_o = cfg.pop_data;   // zero when empty
        if (id_hit)     wb_dat_o = wb_data_t'(`I2S_DEVICE_ID);
    end

    // interrupts, each gated by its enable
    assign rx_intr_o  = irq_en_q[0] & (thresh_q != '0) & (cfg.fifo_level >= thresh_q);
    assign dma_intr_o = irq_en_q[1] & dma_done_q;
    assign ovf_intr_o = irq_en_q[2] & cfg.fifo_overflow;

endmodule

// ==== i2s_rx_top.sv ====
`timescale 1ns/100ps
// i2s slave receive subsystem top, wishbone registers plus sample path
module i2s_rx_top (
    input  logic                 wb_clk_i,
    input  logic                 reset_i,
    // i2s pins
    input  logic                 i2s_clk_i,
    input  logic                 i2s_ws_i,
    input  logic                 i2s_din_i,
    // wishbone slave
    input  wb_bus_pkg::wb_addr_t wb_adr_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  wb_bus_pkg::wb_sel_t  wb_sel_i,
    input  wb_bus_pkg::wb_data_t wb_dat_i,
    output wb_bus_pkg::wb_data_t wb_dat_o,
    output logic                 wb_ack_o,
    // dma handshake
    output logic                 sdma_req_o,
    input  logic                 sdma_active_i,
    input  logic                 sdma_done_i,
    // interrupts
    output logic                 rx_intr_o,
    output logic                 dma_intr_o,
    output logic                 ovf_intr_o
);
    import i2s_audio_pkg::*;

    logic         push;
    stereo_word_t push_data;
    logic         dma_done;

    i2s_rx_cfg_if cfg_if ();

    // ----------------------------------------------------------------------
    // sample path
    // ----------------------------------------------------------------------
    i2s_rx_deserializer u_deserializer (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .i2s_clk_i   (i2s_clk_i),
        .i2s_ws_i    (i2s_ws_i),
        .i2s_din_i   (i2s_din_i),
        .cfg         (cfg_if.datapath),
        .push_o      (push),
        .push_data_o (push_data)
    );

    i2s_sample_fifo u_sample_fifo (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .cfg         (cfg_if.datapath)
    );

    i2s_dma_request u_dma_request (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .cfg           (cfg_if.datapath),
        .sdma_req_o    (sdma_req_o),
        .sdma_active_i (sdma_active_i),
        .sdma_done_i   (sdma_done_i),
        .dma_done_o    (dma_done)
    );

    // software view
    i2s_rx_regs u_regs (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .wb_adr_i   (wb_adr_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_sel_i   (wb_sel_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .cfg        (cfg_if.regs),
        .dma_done_i (dma_done),
        .rx_intr_o  (rx_intr_o),
        .dma_intr_o (dma_intr_o),
        .ovf_intr_o (ovf_intr_o)
    );

endmodule

// ==== i2s_sample_fifo.sv ====
`timescale 1ns/100ps
// stereo sample fifo, circular buffer in the wishbone clock domain
// full fifo drops new words and sets a sticky overflow flag
`include "i2s_rx_config.svh"

module i2s_sample_fifo (
    input  logic                        wb_clk_i,
    input  logic                        reset_i,
    input  logic                        push_i,
    input  i2s_audio_pkg::stereo_word_t push_data_i,
    i2s_rx_cfg_if.datapath              cfg
);
    import i2s_audio_pkg::*;

    localparam int DEPTH = `I2S_FIFO_DEPTH;

    stereo_word_t mem [DEPTH];
    fifo_ptr_t    wr_ptr;
    fifo_ptr_t    rd_ptr;
    fifo_level_t  count;
    logic         ovf_q;
    logic         full;
    logic         empty;
    logic         do_push;
    logic         do_pop;

    assign full    = (count == fifo_level_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push_i & ~full;
    assign do_pop  = cfg.pop & ~empty;   // pop of empty fifo ignored

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge wb_clk_i) begin
        if (reset_i || !cfg.rx_enable) begin
            wr_ptr <= '0;                   // receive off flushes
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            if (do_pop)  rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + fifo_level_t'(1);
                2'b01:   count <= count - fifo_level_t'(1);
                default: count <= count;
            endcase
        end
    end

    // sticky overflow, a new drop wins over a clear
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ovf_q <= 1'b0;
        end else if (push_i && full) begin
            ovf_q <= 1'b1;
        end else if (cfg.ovf_clr) begin
            ovf_q <= 1'b0;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (do_push) mem[wr_ptr] <= push_data_i;
    end

    assign cfg.fifo_level    = count;
    assign cfg.fifo_overflow = ovf_q;
    assign cfg.pop_data      = empty ? '0 : mem[rd_ptr];

endmodule

// ==== project.f ====
+incdir+.
wb_bus_pkg.sv
i2s_audio_pkg.sv
i2s_rx_cfg_if.sv
i2s_rx_deserializer.sv
i2s_sample_fifo.sv
i2s_dma_request.sv
i2s_rx_regs.sv
i2s_rx_top.sv
tb_i2s_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the i2s receive testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_i2s_rx -o vsim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vsim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "simulator exited" sim.log && exit 1 || exit 0

// ==== tb_i2s_rx.sv ====
`timescale 1ns/100ps
// directed testbench for the i2s receive subsystem
// plays the wishbone bridge, the i2s transmitter and the dma controller
`include "i2s_rx_config.svh"

module tb_i2s_rx;
    import wb_bus_pkg::*;

    localparam int BCLK_DIV     = 8;               // wb_clk cycles per bit clock
    localparam int HALF_BIT     = BCLK_DIV / 2;
    localparam int ACK_LIMIT    = 16;              // cycles to wait for ack
    localparam int POLL_LIMIT   = 64;              // status reads per wait
    localparam int FRAME_CYCLES = 2 * `I2S_SLOT_BITS * BCLK_DIV;
    localparam int TOTAL_FRAMES = 3 + 6 + 4 + 18 + 2;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * FRAME_CYCLES + 4000;

    logic        wb_clk;
    logic        reset;
    logic        i2s_clk, i2s_ws, i2s_din;
    wb_addr_t    wb_adr;
    logic        wb_cyc, wb_stb, wb_we;
    wb_sel_t     wb_sel;
    wb_data_t    wb_dat_w, wb_dat_r;
    logic        wb_ack;
    logic        sdma_req, sdma_active, sdma_done;
    logic        rx_intr, dma_intr, ovf_intr;

    logic [31:0] lcg_state;
    logic [31:0] sent_q [$];    // words the fifo should hold with the oldest first
    int          errors, tests_run, tests_failed, cycle_cnt;

    i2s_rx_top i2s_rx_top_i (
        .wb_clk_i (wb_clk), .reset_i (reset),
        .i2s_clk_i (i2s_clk), .i2s_ws_i (i2s_ws), .i2s_din_i (i2s_din),
        .wb_adr_i (wb_adr), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_sel_i (wb_sel), .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
        .sdma_req_o (sdma_req), .sdma_active_i (sdma_active), .sdma_done_i (sdma_done),
        .rx_intr_o (rx_intr), .dma_intr_o (dma_intr), .ovf_intr_o (ovf_intr)
    );

    initial begin
        wb_clk = 1'b0;
        forever #20 wb_clk = ~wb_clk;   // 40 ns period
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    // step to the next edge plus the drive delay where outputs have settled
    task automatic tick();
        @(posedge wb_clk);
        #2;
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // request stays up through the ack cycle and drops after it
    task automatic wb_access(input wb_addr_t addr, input logic we,
                             input wb_data_t wdata, output wb_data_t rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_adr   = addr;
        wb_we    = we;
        wb_dat_w = wdata;
        wb_sel   = 4'hf;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        do begin
            tick();
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        assert (wb_ack) else begin
            $display("no ack from the DUT for address %h at %0t", addr, $time);
            errors++;
        end
        rdata = wb_dat_r;               // valid while ack is high
        tick();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        wb_access(addr, 1'b1, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        wb_access(addr, 1'b0, '0, data);
    endtask

    // poll STATUS until the level matches
    task automatic wait_level(input int exp);
        wb_data_t st;
        int       polls;
        polls = 0;
        do begin
            wb_read(`I2S_REG_STATUS, st);
            polls++;
        end while (int'(st[4:0]) != exp && polls < POLL_LIMIT);
        check_val("status.level", {27'b0, st[4:0]}, exp);
    endtask

    // one i2s bit with ws and data changing while the bit clock is low
    task automatic drive_bit(input logic ws, input logic d);
        i2s_clk = 1'b0;
        i2s_ws  = ws;
        i2s_din = d;
        repeat (HALF_BIT) tick();
        i2s_clk = 1'b1;
        repeat (HALF_BIT) tick();
    endtask

    // one slot, msb first
    task automatic send_slot(input logic ws, input logic [15:0] data);
        for (int i = 15; i >= 0; i--) drive_bit(ws, data[i]);
    endtask

    task automatic send_frame(input logic [15:0] left, input logic [15:0] right);
        send_slot(1'b0, left);
        send_slot(1'b1, right);
    endtask

    // random frames that go into the expected queue when receive is on
    task automatic send_frames(input int n, input bit keep);
        logic [31:0] l, r;
        for (int k = 0; k < n; k++) begin
            l = lcg_next();
            r = lcg_next();
            send_frame(l[31:16], r[31:16]);
            if (keep) sent_q.push_back({l[31:16], r[31:16]});
        end
    endtask

    task automatic read_and_check(input int n);
        wb_data_t d;
        for (int k = 0; k < n; k++) begin
            wb_read(`I2S_REG_DATA, d);
            check_val("DATA word", d, sent_q.size() > 0 ? sent_q.pop_front() : 32'hx);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset_state();
        int       e0;
        wb_data_t d;
        e0 = errors;
        wb_read(`I2S_REG_CTRL, d);
        check_val("CTRL", d, 32'h0);
        wb_read(`I2S_REG_STATUS, d);
        check_val("STATUS", d, 32'h0);
        wb_read(`I2S_REG_ID, d);
        check_val("ID", d, {12'b0, `I2S_DEVICE_ID});
        check_val("sdma_req_o", sdma_req, 0);
        check_val("rx_intr_o", rx_intr, 0);
        check_val("dma_intr_o", dma_intr, 0);
        check_val("ovf_intr_o", ovf_intr, 0);
        finish_test("reset_state", e0);
    endtask

    task automatic test_disabled_rx();
        int          e0;
        logic [31:0] l;
        logic [31:0] r;
        e0 = errors;
        send_frames(2, 0);
        // receive switched on part way into a frame that must be dropped
        l = lcg_next();
        r = lcg_next();
        send_slot(1'b0, l[31:16]);
        wb_write(`I2S_REG_CTRL, 32'h1);
        send_slot(1'b1, r[31:16]);
        repeat (8) tick();
        wait_level(0);
        finish_test("disabled_rx", e0);
    endtask

    task automatic test_data_path();
        int e0;
        e0 = errors;
        wb_write(`I2S_REG_CTRL, 32'h1);          // rx enable
        send_frames(6, 1);
        wait_level(6);
        read_and_check(6);
        wait_level(0);
        finish_test("data_path", e0);
    endtask

    task automatic test_level_irq();
        int e0;
        e0 = errors;
        wb_write(`I2S_REG_CTRL, 32'h405);        // threshold 4, rx irq, rx on
        send_frames(3, 1);
        wait_level(3);
        check_val("rx_intr_o", rx_intr, 0);
        send_frames(1, 1);
        wait_level(4);
        check_val("rx_intr_o", rx_intr, 1);
        read_and_check(2);
        check_val("rx_intr_o", rx_intr, 0);      // level 2 is below threshold
        finish_test("level_irq", e0);
    endtask

    task automatic test_overflow();
        int       e0;
        wb_data_t d;
        e0 = errors;
        wb_write(`I2S_REG_CTRL, 32'h0);          // flush leftovers
        sent_q.delete();
        wb_write(`I2S_REG_CTRL, 32'h11);         // ovf irq, rx on
        send_frames(18, 1);
        while (sent_q.size() > `I2S_FIFO_DEPTH) void'(sent_q.pop_back()); // dropped
        wait_level(`I2S_FIFO_DEPTH);
        wb_read(`I2S_REG_STATUS, d);
        check_val("status.overflow", {31'b0, d[8]}, 1);
        check_val("ovf_intr_o", ovf_intr, 1);
        read_and_check(`I2S_FIFO_DEPTH);
        wb_write(`I2S_REG_STATUS, 32'h100);      // write-1 clear
        wb_read(`I2S_REG_STATUS, d);
        check_val("status.overflow", {31'b0, d[8]}, 0);
        check_val("ovf_intr_o", ovf_intr, 0);
        finish_test("overflow", e0);
    endtask

    task automatic test_dma();
        int       e0;
        int       waited;
        wb_data_t d;
        e0 = errors;
        wb_write(`I2S_REG_CTRL, 32'h20B);        // threshold 2, dma irq, dma, rx
        send_frames(2, 1);
        waited = 0;
        while (!sdma_req && waited < POLL_LIMIT) begin
            tick();
            waited++;
        end
        check_val("sdma_req_o", sdma_req, 1);
        sdma_active = 1'b1;
        waited = 0;
        do begin
            tick();
            waited++;
        end while (sdma_req && waited < ACK_LIMIT);
        check_val("sdma_req_o", sdma_req, 0);
        read_and_check(2);
        sdma_done = 1'b1;                        // one-cycle end of burst
        tick();
        sdma_done   = 1'b0;
        sdma_active = 1'b0;
        tick();
        check_val("dma_intr_o", dma_intr, 1);
        wb_read(`I2S_REG_STATUS, d);
        check_val("status.dma_done", {31'b0, d[9]}, 1);
        wb_write(`I2S_REG_STATUS, 32'h200);
        wb_read(`I2S_REG_STATUS, d);
        check_val("status.dma_done", {31'b0, d[9]}, 0);
        check_val("dma_intr_o", dma_intr, 0);
        finish_test("dma", e0);
    endtask

    // ----------------------------------------------------------------------
    // run control
    // ----------------------------------------------------------------------
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge wb_clk);
            cycle_cnt++;
        end
        $display("timeout, run stopped after %0d cycles", cycle_cnt);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        i2s_clk      = 1'b0;
        i2s_ws       = 1'b1;                     // idle in the right slot
        i2s_din      = 1'b0;
        wb_adr       = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_sel       = '0;
        wb_dat_w     = '0;
        sdma_active  = 1'b0;
        sdma_done    = 1'b0;
        lcg_state    = 32'hb67b91ef;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) tick();
        reset = 1'b0;
        tick();
        test_reset_state();
        test_disabled_rx();
        test_data_path();
        test_level_irq();
        test_overflow();
        test_dma();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== wb_bus_pkg.sv ====
// wishbone slave side vector types
// widths follow the processor bridge into the fabric
package wb_bus_pkg;

    // byte address from the bridge
    typedef logic [16:0] wb_addr_t;

    // read and write data
    typedef logic [31:0] wb_data_t;

    // byte strobes, one per data lane
    typedef logic [3:0]  wb_sel_t;

endpackage
